// ==== hw/mipsPkg.sv ====
package mipsPkg;

	////////////////////////////////////////////////////////////
	// Widths
	////////////////////////////////////////////////////////////

	localparam int dataWidth = 32; // Register and memory word
	localparam int regIndexWidth = 5; // 32 registers
	localparam int opcodeWidth = 6; // IR bits 31:26
	localparam int functWidth = 6; // IR bits 5:0

	////////////////////////////////////////////////////////////
	// Opcodes and R-type funct codes
	////////////////////////////////////////////////////////////

	localparam logic [opcodeWidth-1:0] opR = 6'b000000; // Funct selects the operation
	localparam logic [opcodeWidth-1:0] opAddi = 6'b001000;
	localparam logic [opcodeWidth-1:0] opSlti = 6'b001010;
	localparam logic [opcodeWidth-1:0] opAndi = 6'b001100; // Zero-extended imm
	localparam logic [opcodeWidth-1:0] opOri = 6'b001101; // Zero-extended imm
	localparam logic [opcodeWidth-1:0] opXori = 6'b001110; // Zero-extended imm
	localparam logic [opcodeWidth-1:0] opLui = 6'b001111;
	localparam logic [opcodeWidth-1:0] opLw = 6'b100011; // Word load only
	localparam logic [opcodeWidth-1:0] opSw = 6'b101011; // Word store only

	localparam logic [functWidth-1:0] fnAdd = 6'b100000;
	localparam logic [functWidth-1:0] fnSub = 6'b100010;
	localparam logic [functWidth-1:0] fnAnd = 6'b100100;
	localparam logic [functWidth-1:0] fnOr = 6'b100101;
	localparam logic [functWidth-1:0] fnXor = 6'b100110;
	localparam logic [functWidth-1:0] fnNor = 6'b100111;
	localparam logic [functWidth-1:0] fnSlt = 6'b101010; // Signed compare
	localparam logic [functWidth-1:0] fnSltu = 6'b101011; // Unsigned compare
	localparam logic [functWidth-1:0] fnSll = 6'b000000; // Shift amount from rt
	localparam logic [functWidth-1:0] fnSrl = 6'b000010;
	localparam logic [functWidth-1:0] fnSra = 6'b000011;

	////////////////////////////////////////////////////////////
	// Control unit to ALU requests
	////////////////////////////////////////////////////////////

	localparam int aluOpWidth = 3;
	localparam logic [aluOpWidth-1:0] aluUseFunct = 3'd0; // R-type, decode funct
	localparam logic [aluOpWidth-1:0] aluAdd = 3'd1; // Also address calc
	localparam logic [aluOpWidth-1:0] aluSlt = 3'd2;
	localparam logic [aluOpWidth-1:0] aluAnd = 3'd3;
	localparam logic [aluOpWidth-1:0] aluOr = 3'd4;
	localparam logic [aluOpWidth-1:0] aluXor = 3'd5;
	localparam logic [aluOpWidth-1:0] aluLui = 3'd6; // B shifted up 16

	localparam int aluSrcWidth = 2;
	localparam logic [aluSrcWidth-1:0] srcReg = 2'd0; // B from rt
	localparam logic [aluSrcWidth-1:0] srcSignImm = 2'd1;
	localparam logic [aluSrcWidth-1:0] srcZeroImm = 2'd2;

	////////////////////////////////////////////////////////////
	// Instruction word, two views of the same 32 bits
	////////////////////////////////////////////////////////////

	typedef union packed {
		struct packed {
			logic [opcodeWidth-1:0] opcode;
			logic [regIndexWidth-1:0] rs; // Operand A
			logic [regIndexWidth-1:0] rt; // Operand B or shift amount
			logic [regIndexWidth-1:0] rd; // R-type destination
			logic [regIndexWidth-1:0] shamt; // Ignored by the shifts here
			logic [functWidth-1:0] funct;
		} rType;
		struct packed {
			logic [opcodeWidth-1:0] opcode;
			logic [regIndexWidth-1:0] rs; // Base or operand A
			logic [regIndexWidth-1:0] rt; // Destination, or store data
			logic [15:0] imm;
		} iType;
	} instrWord;

endpackage

// ==== hw/alu.sv ====
module alu (
	input logic [mipsPkg::aluOpWidth-1:0] aluOp,
	input logic [mipsPkg::functWidth-1:0] funct,
	input logic [mipsPkg::dataWidth-1:0] a,
	input logic [mipsPkg::dataWidth-1:0] b,
	output logic [mipsPkg::dataWidth-1:0] result
);
	import mipsPkg::*;

	// Internal code for lui, outside the funct space used here
	localparam logic [functWidth-1:0] luiOperation = 6'b111111;

	logic [functWidth-1:0] operation;
	logic [4:0] shiftAmount;

	assign shiftAmount = b[4:0]; // Low five bits of rt

	////////////////////////////////////////////////////////////
	// Request to operation
	////////////////////////////////////////////////////////////

	always_comb begin
		case (aluOp)
			aluUseFunct: operation = funct; // R-type passes funct through
			aluAdd: operation = fnAdd;
			aluSlt: operation = fnSlt;
			aluAnd: operation = fnAnd;
			aluOr: operation = fnOr;
			aluXor: operation = fnXor;
			aluLui: operation = luiOperation;
			default: operation = fnAdd;
		endcase
	end

	////////////////////////////////////////////////////////////
	// Arithmetic, logic, compare, shift
	////////////////////////////////////////////////////////////

	always_comb begin
		case (operation)
			fnAdd: result = a + b; // Wraps
			fnSub: result = a - b;
			fnAnd: result = a & b;
			fnOr: result = a | b;
			fnXor: result = a ^ b;
			fnNor: result = ~(a | b);
			fnSlt: result = {{(dataWidth-1){1'b0}}, $signed(a) < $signed(b)};
			fnSltu: result = {{(dataWidth-1){1'b0}}, a < b};
			fnSll: result = a << shiftAmount;
			fnSrl: result = a >> shiftAmount;
			fnSra: result = $signed(a) >>> shiftAmount; // Sign fill
			luiOperation: result = b << 16; // Imm to upper half
			default: result = '0; // Unknown funct gives zero
		endcase
	end

endmodule

// ==== hw/regFile.sv ====
module regFile (
	input logic CLK,
	input logic reset,
	input logic [mipsPkg::regIndexWidth-1:0] readAddrA,
	input logic [mipsPkg::regIndexWidth-1:0] readAddrB,
	input logic [mipsPkg::regIndexWidth-1:0] writeAddr,
	input logic [mipsPkg::dataWidth-1:0] writeData,
	input logic writeEn,
	output logic [mipsPkg::dataWidth-1:0] readDataA,
	output logic [mipsPkg::dataWidth-1:0] readDataB
);
	import mipsPkg::*;

	logic [dataWidth-1:0] regs [0:(1 << regIndexWidth)-1];

	always_ff @(posedge CLK) begin
		if (reset) begin
			for (int i = 0; i < (1 << regIndexWidth); i++) begin
				regs[i] <= '0;
			end
			readDataA <= '0;
			readDataB <= '0;
		end else begin
			// r0 never written so it reads zero
			if (writeEn && (writeAddr != '0)) begin
				regs[writeAddr] <= writeData;
			end
			readDataA <= regs[readAddrA]; // Old value on same-edge write
			readDataB <= regs[readAddrB];
		end
	end

endmodule

// ==== hw/controlUnit.sv ====
module controlUnit (
	input logic CLK,
	input logic reset,
	input logic memReady,
	input logic [mipsPkg::opcodeWidth-1:0] opcode,
	output logic pcLoad,
	output logic irLoad,
	output logic marLoad,
	output logic mdrLoad,
	output logic regWrite,
	output logic marSelAlu, // MAR from ALU, else PC
	output logic regInMem, // Write-back from MDR, else ALU
	output logic regDstRd, // Destination rd, else rt
	output logic memRead,
	output logic memWrite,
	output logic [mipsPkg::aluSrcWidth-1:0] aluSrc,
	output logic [mipsPkg::aluOpWidth-1:0] aluOp
);
	import mipsPkg::*;

	////////////////////////////////////////////////////////////
	// State encoding
	////////////////////////////////////////////////////////////

	localparam logic [3:0] fetchAddr = 4'd0; // MAR <= PC
	localparam logic [3:0] fetchWait = 4'd1; // Read until memReady
	localparam logic [3:0] decode = 4'd2; // Regfile reads rs, rt
	localparam logic [3:0] execute = 4'd3; // ALU op and write-back
	localparam logic [3:0] loadAddr = 4'd4; // MAR <= rs + imm
	localparam logic [3:0] readWait = 4'd5; // MDR <= memory
	localparam logic [3:0] loadWrite = 4'd6; // rt <= MDR
	localparam logic [3:0] storeAddr = 4'd7; // MAR <= rs + imm, MDR <= rt
	localparam logic [3:0] writeWait = 4'd8; // Write until memReady

	logic [3:0] state, nextState;

	always_ff @(posedge CLK) begin
		if (reset) begin
			state <= fetchAddr;
		end else begin
			state <= nextState;
		end
	end

	////////////////////////////////////////////////////////////
	// Next-state decoding
	////////////////////////////////////////////////////////////

	always_comb begin
		nextState = fetchAddr; // Most states end the instruction
		case (state)
			fetchAddr: nextState = fetchWait;
			fetchWait: nextState = memReady ? decode : fetchWait;
			decode: begin
				case (opcode)
					opR, opAddi, opSlti, opAndi, opOri, opXori, opLui: nextState = execute;
					opLw: nextState = loadAddr;
					opSw: nextState = storeAddr;
					default: nextState = fetchAddr; // Unknown opcode is dropped
				endcase
			end
			execute: nextState = fetchAddr;
			loadAddr: nextState = readWait;
			readWait: nextState = memReady ? loadWrite : readWait;
			loadWrite: nextState = fetchAddr;
			storeAddr: nextState = writeWait;
			writeWait: nextState = memReady ? fetchAddr : writeWait;
			default: nextState = fetchAddr;
		endcase
	end

	////////////////////////////////////////////////////////////
	// Control-signal encoding
	////////////////////////////////////////////////////////////

	always_comb begin
		pcLoad = 1'b0;
		irLoad = 1'b0;
		marLoad = 1'b0;
		mdrLoad = 1'b0;
		regWrite = 1'b0;
		marSelAlu = 1'b0;
		regInMem = 1'b0;
		regDstRd = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		aluOp = aluAdd; // Effective address by default
		aluSrc = srcSignImm;
		case (state)
			fetchAddr: marLoad = 1'b1; // PC into MAR
			fetchWait: begin
				memRead = 1'b1;
				irLoad = memReady; // IR and PC step on the ending edge
				pcLoad = memReady;
			end
			execute: begin
				regWrite = 1'b1;
				regDstRd = (opcode == opR);
				case (opcode)
					opR: begin
						aluOp = aluUseFunct;
						aluSrc = srcReg;
					end
					opSlti: aluOp = aluSlt; // Keeps sign-extended imm
					opAndi: begin
						aluOp = aluAnd;
						aluSrc = srcZeroImm;
					end
					opOri: begin
						aluOp = aluOr;
						aluSrc = srcZeroImm;
					end
					opXori: begin
						aluOp = aluXor;
						aluSrc = srcZeroImm;
					end
					opLui: begin
						aluOp = aluLui;
						aluSrc = srcZeroImm;
					end
					default: aluOp = aluAdd; // addi
				endcase
			end
			loadAddr: begin
				marLoad = 1'b1;
				marSelAlu = 1'b1;
			end
			readWait: begin
				memRead = 1'b1;
				mdrLoad = memReady; // Catch data with the ready edge
			end
			loadWrite: begin
				regWrite = 1'b1;
				regInMem = 1'b1; // rt from MDR
			end
			storeAddr: begin
				marLoad = 1'b1;
				marSelAlu = 1'b1;
				mdrLoad = 1'b1; // rt into MDR alongside the address
			end
			writeWait: memWrite = 1'b1;
			default: memWrite = 1'b0; // decode drives nothing
		endcase
	end

endmodule

// ==== hw/dataPath.sv ====
module dataPath #(
	parameter int addrWidth = 9
) (
	input logic CLK,
	input logic reset,
	input logic pcLoad, // PC += 4
	input logic irLoad,
	input logic marLoad,
	input logic mdrLoad,
	input logic regWrite,
	input logic marSelAlu,
	input logic regInMem,
	input logic regDstRd,
	input logic [mipsPkg::aluSrcWidth-1:0] aluSrc,
	input logic [mipsPkg::aluOpWidth-1:0] aluOp,
	input logic [mipsPkg::dataWidth-1:0] memReadData,
	output logic [mipsPkg::opcodeWidth-1:0] opcode,
	output logic [addrWidth-1:0] memAddr,
	output logic [mipsPkg::dataWidth-1:0] memWriteData
);
	import mipsPkg::*;

	logic [addrWidth-1:0] pc;
	logic [addrWidth-1:0] mar;
	logic [addrWidth-1:0] marIn;
	instrWord ir;
	logic [dataWidth-1:0] mdr;
	logic [dataWidth-1:0] mdrIn;

	logic [dataWidth-1:0] readDataA, readDataB; // Registered in decode
	logic [dataWidth-1:0] signImm, zeroImm, operandB;
	logic [dataWidth-1:0] aluResult;
	logic [dataWidth-1:0] regIn;
	logic [regIndexWidth-1:0] destReg;

	////////////////////////////////////////////////////////////
	// PC and IR
	////////////////////////////////////////////////////////////

	always_ff @(posedge CLK) begin
		if (reset) begin
			pc <= '0;
			ir <= '0;
		end else begin
			if (pcLoad) pc <= pc + addrWidth'(4);
			if (irLoad) ir <= memReadData;
		end
	end

	assign opcode = ir.rType.opcode;

	////////////////////////////////////////////////////////////
	// Memory address and data registers
	////////////////////////////////////////////////////////////

	// Effective address forced to a word boundary
	assign marIn = marSelAlu ? {aluResult[addrWidth-1:2], 2'b00} : pc;
	// Store address cycle loads MAR too, read wait does not
	assign mdrIn = marLoad ? readDataB : memReadData;

	always_ff @(posedge CLK) begin
		if (marLoad) mar <= marIn;
		if (mdrLoad) mdr <= mdrIn;
	end

	assign memAddr = mar;
	assign memWriteData = mdr;

	////////////////////////////////////////////////////////////
	// Operand and write-back selection
	////////////////////////////////////////////////////////////

	assign signImm = {{(dataWidth-16){ir.iType.imm[15]}}, ir.iType.imm};
	assign zeroImm = {{(dataWidth-16){1'b0}}, ir.iType.imm};

	always_comb begin
		case (aluSrc)
			srcSignImm: operandB = signImm; // addi, slti, lw, sw
			srcZeroImm: operandB = zeroImm; // Logical imm and lui
			default: operandB = readDataB;
		endcase
	end

	assign destReg = regDstRd ? ir.rType.rd : ir.iType.rt;
	assign regIn = regInMem ? mdr : aluResult;

	regFile rf (
		.CLK(CLK),
		.reset(reset),
		.readAddrA(ir.rType.rs),
		.readAddrB(ir.rType.rt),
		.writeAddr(destReg),
		.writeData(regIn),
		.writeEn(regWrite),
		.readDataA(readDataA),
		.readDataB(readDataB)
	);

	alu alu0 (
		.aluOp(aluOp),
		.funct(ir.rType.funct),
		.a(readDataA),
		.b(operandB),
		.result(aluResult)
	);

endmodule

// ==== hw/mipsTop.sv ====
module mipsTop #(
	parameter int addrWidth = 9 // Byte address into external memory
) (
	input logic CLK,
	input logic reset,
	input logic [mipsPkg::dataWidth-1:0] memReadData,
	input logic memReady, // Memory answer level
	output logic [addrWidth-1:0] memAddr,
	output logic [mipsPkg::dataWidth-1:0] memWriteData,
	output logic memRead,
	output logic memWrite
);
	import mipsPkg::*;

	// Strobes from the FSM
	logic pcLoad, irLoad, marLoad, mdrLoad, regWrite;
	logic marSelAlu, regInMem, regDstRd;
	logic [aluSrcWidth-1:0] aluSrc;
	logic [aluOpWidth-1:0] aluOp;
	logic [opcodeWidth-1:0] opcode; // Back from IR

	controlUnit cu (
		.CLK(CLK),
		.reset(reset),
		.memReady(memReady),
		.opcode(opcode),
		.pcLoad(pcLoad),
		.irLoad(irLoad),
		.marLoad(marLoad),
		.mdrLoad(mdrLoad),
		.regWrite(regWrite),
		.marSelAlu(marSelAlu),
		.regInMem(regInMem),
		.regDstRd(regDstRd),
		.memRead(memRead),
		.memWrite(memWrite),
		.aluSrc(aluSrc),
		.aluOp(aluOp)
	);

	dataPath #(.addrWidth(addrWidth)) dp (
		.CLK(CLK),
		.reset(reset),
		.pcLoad(pcLoad),
		.irLoad(irLoad),
		.marLoad(marLoad),
		.mdrLoad(mdrLoad),
		.regWrite(regWrite),
		.marSelAlu(marSelAlu),
		.regInMem(regInMem),
		.regDstRd(regDstRd),
		.aluSrc(aluSrc),
		.aluOp(aluOp),
		.memReadData(memReadData),
		.opcode(opcode),
		.memAddr(memAddr),
		.memWriteData(memWriteData)
	);

endmodule

// ==== test/clockGen.sv ====
module clockGen #(
	parameter int period = 100,
	parameter int resetCycles = 10
) (
	output logic CLK,
	output logic reset
);

	initial begin
		CLK = 1'b0;
		forever #(period / 2) CLK = ~CLK; // Free-running
	end

	initial begin
		reset = 1'b1;
		repeat (resetCycles) @(posedge CLK); // Held for the reset cycles
		@(negedge CLK); // Drop away from the sampling edge
		reset = 1'b0;
	end

endmodule

// ==== test/memProtocol_sva.sv ====
module memProtocol #(
	parameter int addrWidth = 9
) (
	input logic CLK,
	input logic reset,
	input logic [addrWidth-1:0] memAddr,
	input logic [mipsPkg::dataWidth-1:0] memWriteData,
	input logic memRead,
	input logic memWrite,
	input logic memReady
);

	////////////////////////////////////////////////////////////
	// Memory bus rules
	////////////////////////////////////////////////////////////

	property strobesExclusive; // One access at a time
		@(posedge CLK) disable iff (reset) !(memRead && memWrite);
	endproperty

	property readHeld; // Read address frozen until ready
		@(posedge CLK) disable iff (reset)
			(memRead && !memReady) |=> (memRead && $stable(memAddr));
	endproperty

	property writeHeld; // Address and data frozen until ready
		@(posedge CLK) disable iff (reset)
			(memWrite && !memReady) |=> (memWrite && $stable(memAddr) && $stable(memWriteData));
	endproperty

	property quietAfterReset;
		@(posedge CLK) reset |=> (!memRead && !memWrite);
	endproperty

	strobesExclusiveCheck: assert property (strobesExclusive)
		else $error("memRead and memWrite high together");
	readHeldCheck: assert property (readHeld)
		else $error("Read request changed before memReady");
	writeHeldCheck: assert property (writeHeld)
		else $error("Write request changed before memReady");
	quietAfterResetCheck: assert property (quietAfterReset)
		else $error("Memory strobe high right after reset");

endmodule

bind mipsTop memProtocol #(.addrWidth(addrWidth)) memCheck (
	.CLK(CLK),
	.reset(reset),
	.memAddr(memAddr),
	.memWriteData(memWriteData),
	.memRead(memRead),
	.memWrite(memWrite),
	.memReady(memReady)
);

// ==== test/mipsTopTb.sv ====
module mipsTopTb;
	import mipsPkg::*;

	localparam int addrWidth = 9;
	localparam int memWordCount = 1 << (addrWidth - 2); // Whole byte space in words
	localparam logic [dataWidth-1:0] loadWord = 32'h8badf00d; // Source for lw test
	localparam logic [addrWidth-1:0] loadAddr = 9'h1f0;

	logic CLK, reset;
	logic [dataWidth-1:0] memReadData;
	logic memReady;
	logic [addrWidth-1:0] memAddr;
	logic [dataWidth-1:0] memWriteData;
	logic memRead, memWrite;

	logic [dataWidth-1:0] memWords [0:memWordCount-1];

	// Program table: instruction, expected bus address, expected data
	instrWord tableInstr[$];
	logic [addrWidth-1:0] tableAddr[$];
	logic [dataWidth-1:0] tableData[$];
	logic [addrWidth-1:0] storeSlot; // Next free result word

	// Bus accesses as seen by the memory model
	bit accessIsWrite[$];
	logic [addrWidth-1:0] accessAddr[$];
	logic [dataWidth-1:0] accessData[$];

	int passCount = 0;
	int failCount = 0;
	int recordCount = 0;

	clockGen #(.period(100), .resetCycles(10)) clocks (.CLK(CLK), .reset(reset));

	mipsTop #(.addrWidth(addrWidth)) uut (
		.CLK(CLK),
		.reset(reset),
		.memReadData(memReadData),
		.memReady(memReady),
		.memAddr(memAddr),
		.memWriteData(memWriteData),
		.memRead(memRead),
		.memWrite(memWrite)
	);

	////////////////////////////////////////////////////////////
	// Instruction encoding and table building
	////////////////////////////////////////////////////////////

	function automatic instrWord encodeR(input logic [functWidth-1:0] funct,
			input int rd, input int rs, input int rt);
		instrWord w;
		w.rType.opcode = opR;
		w.rType.rs = regIndexWidth'(rs);
		w.rType.rt = regIndexWidth'(rt);
		w.rType.rd = regIndexWidth'(rd);
		w.rType.shamt = '0; // Shifts take rt instead
		w.rType.funct = funct;
		return w;
	endfunction

	function automatic instrWord encodeI(input logic [opcodeWidth-1:0] op,
			input int rt, input int rs, input logic [15:0] imm);
		instrWord w;
		w.iType.opcode = op;
		w.iType.rs = regIndexWidth'(rs);
		w.iType.rt = regIndexWidth'(rt);
		w.iType.imm = imm;
		return w;
	endfunction

	task automatic aluRecord(input instrWord w);
		tableInstr.push_back(w);
		tableAddr.push_back('0); // No data access
		tableData.push_back('0);
	endtask

	task automatic loadRecord(input int rt, input logic [addrWidth-1:0] addr);
		tableInstr.push_back(encodeI(opLw, rt, 0, 16'(addr))); // Base r0
		tableAddr.push_back(addr);
		tableData.push_back(loadWord);
	endtask

	task automatic storeRecord(input int rt, input logic [dataWidth-1:0] expected);
		tableInstr.push_back(encodeI(opSw, rt, 0, 16'(storeSlot)));
		tableAddr.push_back(storeSlot);
		tableData.push_back(expected);
		storeSlot = storeSlot + addrWidth'(4);
	endtask

	task automatic buildTable();
		storeSlot = 9'h180; // Result area above the program
		aluRecord(encodeI(opAddi, 1, 0, 16'h7fff));
		storeRecord(1, 32'h00007fff);
		aluRecord(encodeI(opAddi, 2, 0, 16'hffff)); // Sign-extended -1
		storeRecord(2, 32'hffffffff);
		aluRecord(encodeI(opLui, 3, 0, 16'h8000));
		aluRecord(encodeI(opOri, 3, 3, 16'h0001));
		storeRecord(3, 32'h80000001);
		aluRecord(encodeI(opAndi, 4, 2, 16'h8f0f)); // Zero-extended mask
		storeRecord(4, 32'h00008f0f);
		aluRecord(encodeI(opXori, 5, 3, 16'hffff));
		storeRecord(5, 32'h8000fffe);
		aluRecord(encodeI(opSlti, 6, 2, 16'h0005)); // -1 < 5
		storeRecord(6, 32'h00000001);
		aluRecord(encodeR(fnAdd, 7, 3, 2)); // Wraps past bit 31
		storeRecord(7, 32'h80000000);
		aluRecord(encodeR(fnSub, 8, 1, 3));
		storeRecord(8, 32'h80007ffe);
		aluRecord(encodeR(fnAnd, 9, 3, 5));
		storeRecord(9, 32'h80000000);
		aluRecord(encodeR(fnOr, 10, 1, 3));
		storeRecord(10, 32'h80007fff);
		aluRecord(encodeR(fnXor, 11, 3, 5));
		storeRecord(11, 32'h0000ffff);
		aluRecord(encodeR(fnNor, 12, 1, 4));
		storeRecord(12, 32'hffff0000);
		aluRecord(encodeR(fnSlt, 13, 2, 1)); // Signed, -1 below 0x7fff
		storeRecord(13, 32'h00000001);
		aluRecord(encodeR(fnSltu, 14, 1, 2)); // Unsigned, 0x7fff below max
		storeRecord(14, 32'h00000001);
		aluRecord(encodeI(opAddi, 15, 0, 16'h0024)); // Low five bits give 4
		aluRecord(encodeR(fnSll, 16, 3, 15));
		storeRecord(16, 32'h00000010);
		aluRecord(encodeR(fnSrl, 17, 3, 15));
		storeRecord(17, 32'h08000000);
		aluRecord(encodeR(fnSra, 18, 3, 15)); // Sign bit copied in
		storeRecord(18, 32'hf8000000);
		aluRecord(encodeI(opAddi, 0, 0, 16'h1234)); // r0 stays zero
		storeRecord(0, 32'h00000000);
		loadRecord(19, loadAddr);
		storeRecord(19, loadWord);
	endtask

	task automatic loadMemory();
		for (int i = 0; i < memWordCount; i++) begin
			memWords[i] = {~16'(i), 16'(i)}; // Fill decodes as unknown opcode
		end
		for (int i = 0; i < tableInstr.size(); i++) begin
			memWords[i] = tableInstr[i]; // Program from address 0
		end
		memWords[loadAddr[addrWidth-1:2]] = loadWord;
	endtask

	////////////////////////////////////////////////////////////
	// Memory model with random ready delay
	////////////////////////////////////////////////////////////

	initial begin
		bit busy;
		int waitCycles;
		busy = 1'b0;
		waitCycles = 0;
		memReady = 1'b0;
		memReadData = '0;
		void'($urandom(32'h2be8));
		forever begin
			@(negedge CLK);
			if (memReady) begin
				memReady = 1'b0; // Access ended on the last rising edge
				busy = 1'b0;
			end else if (!reset && (memRead || memWrite)) begin
				if (!busy) begin
					busy = 1'b1;
					waitCycles = int'($urandom % 4); // 0 to 3 cycles late
					accessIsWrite.push_back(memWrite);
					accessAddr.push_back(memAddr);
					accessData.push_back(memWriteData);
				end
				if (waitCycles == 0) begin
					memReady = 1'b1;
					if (memWrite) begin
						memWords[memAddr[addrWidth-1:2]] = memWriteData;
					end else begin
						memReadData = memWords[memAddr[addrWidth-1:2]];
					end
				end else begin
					waitCycles--;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Compare tasks and access queue
	////////////////////////////////////////////////////////////

	task automatic checkAddr(input string name, input logic [addrWidth-1:0] actual,
			input logic [addrWidth-1:0] expected);
		if (actual === expected) begin
			passCount++;
			$display("[PASS] %s = 0x%h", name, actual);
		end else begin
			failCount++;
			$display("[FAIL] %s = 0x%h, expected 0x%h", name, actual, expected);
		end
	endtask

	task automatic checkData(input string name, input logic [dataWidth-1:0] actual,
			input logic [dataWidth-1:0] expected);
		if (actual === expected) begin
			passCount++;
			$display("[PASS] %s = 0x%h", name, actual);
		end else begin
			failCount++;
			$display("[FAIL] %s = 0x%h, expected 0x%h", name, actual, expected);
		end
	endtask

	task automatic reportProblem(input string text);
		failCount++;
		$display("%s", text);
	endtask

	task automatic nextAccess(output bit isWrite, output logic [addrWidth-1:0] addr,
			output logic [dataWidth-1:0] data);
		while (accessIsWrite.size() == 0) begin
			@(posedge CLK); // Queue fills on falling edges only
		end
		isWrite = accessIsWrite.pop_front();
		addr = accessAddr.pop_front();
		data = accessData.pop_front();
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////

	initial begin
		bit isWrite;
		logic [addrWidth-1:0] addr;
		logic [dataWidth-1:0] data;
		logic [opcodeWidth-1:0] op;
		buildTable();
		loadMemory();
		recordCount = tableInstr.size();
		for (int i = 0; i < recordCount; i++) begin
			nextAccess(isWrite, addr, data);
			if (isWrite) begin
				reportProblem($sformatf("Record %0d: unexpected store to 0x%h instead of a fetch",
					i, addr));
			end else begin
				checkAddr($sformatf("memAddr, fetch %0d", i), addr, addrWidth'(i * 4));
			end
			op = tableInstr[i].iType.opcode;
			if (op == opLw) begin
				nextAccess(isWrite, addr, data);
				if (isWrite) begin
					reportProblem($sformatf("Record %0d: unexpected store where a load belongs", i));
				end else begin
					checkAddr($sformatf("memAddr, load %0d", i), addr, tableAddr[i]);
				end
			end else if (op == opSw) begin
				nextAccess(isWrite, addr, data);
				if (!isWrite) begin
					reportProblem($sformatf("Record %0d: store missing, read of 0x%h came instead",
						i, addr));
				end else begin
					checkAddr($sformatf("memAddr, store %0d", i), addr, tableAddr[i]);
					checkData($sformatf("memWriteData, store %0d", i), data, tableData[i]);
				end
			end
		end
		// Next fetch closes the last record
		nextAccess(isWrite, addr, data);
		if (isWrite) begin
			reportProblem("Unexpected store after the last instruction");
		end else begin
			checkAddr("memAddr, fetch after program", addr, addrWidth'(recordCount * 4));
		end
		$display("Checks passed: %0d, failed: %0d", passCount, failCount);
		if (failCount == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

	// Watchdog, 12 cycles per record with a margin of 4
	initial begin
		wait (recordCount > 0);
		#(recordCount * 12 * 4 * 100);
		$display("Timeout: the program did not finish in %0d cycles", recordCount * 12 * 4);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

// ==== list.f ====
hw/mipsPkg.sv
hw/alu.sv
hw/regFile.sv
hw/controlUnit.sv
hw/dataPath.sv
hw/mipsTop.sv
test/clockGen.sv
test/memProtocol_sva.sv
test/mipsTopTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module mipsTopTb -f list.f \
	&& obj_dir/VmipsTopTb 2>&1 | tee sim.log
grep -qx "TESTS PASSED" sim.log \
	&& echo "Simulation run: pass" \
	|| { echo "Simulation run: fail, see sim.log"; exit 1; }
